// File: common/dispatch_if.sv
/*
  dispatch interface
  one dispatch transaction: the handshake qualifiers and register indices
  from the top level, the renamed sources and old mapping from the map
  table, and the new tag plus empty flag from the free list.
*/
interface dispatch_if;
  import rename_pkg::*;

  // handshake result, formed at the top level
  logic      fire;
  logic      renames;
  arch_reg_t dest;
  arch_reg_t src_a;
  arch_reg_t src_b;

  // map table lookups
  phys_tag_t t1;
  logic      t1_ready;
  phys_tag_t t2;
  logic      t2_ready;
  phys_tag_t t_old;

  // free list head
  phys_tag_t t_new;
  logic      empty;

  modport map (input renames, dest, src_a, src_b, t_new,
               output t1, t1_ready, t2, t2_ready, t_old);
  modport free (input renames, output t_new, empty);
  modport rob (input fire, dest, t_new, t_old);

endinterface

// File: common/rename_pkg.sv
/*
  rename package
  shared widths, register counts and tag types for the rename core:
  architectural register index, physical tag, the zero register and
  the default sizing of the free list and the reorder buffer.
*/
package rename_pkg;

  ////////////////////
  // widths
  ////////////////////

  // 32 architectural registers, 5-bit index
  localparam int arch_reg_w    = 5;
  localparam int num_arch_regs = 32;

  // physical tag space up to 64 entries
  localparam int phys_tag_w = 6;

  typedef logic [arch_reg_w-1:0] arch_reg_t;
  typedef logic [phys_tag_w-1:0] phys_tag_t;

  ////////////////////
  // special registers
  ////////////////////

  // r31 reads as zero, never renamed, always maps to p31
  localparam arch_reg_t zero_reg = arch_reg_t'(31);

  ////////////////////
  // default sizing
  ////////////////////

  // 32 tags live in the map after reset, the rest start in the free list
  // anything from 33 to 64 works
  localparam int default_num_phys = 40;

  // power of two, 4 to 32
  localparam int default_rob_depth = 16;

endpackage

// File: common/retire_if.sv
/*
  retire interface
  the ROB head as it retires: valid strobe, architectural destination,
  and the new and old physical tags of that instruction.
*/
interface retire_if;
  import rename_pkg::*;

  // high while the head is complete, pops on the same edge
  logic      valid;
  arch_reg_t arch_reg;
  phys_tag_t t_new;
  // goes back to the free list unless arch_reg is r31
  phys_tag_t t_old;

  modport rob (output valid, arch_reg, t_new, t_old);
  modport free (input valid, arch_reg, t_old);

endinterface

// File: compile.f
common/rename_pkg.sv
common/dispatch_if.sv
common/retire_if.sv
rename/map_table.sv
rename/free_list.sv
rob/rob.sv
source/rename_core.sv
sim/rename_tb_pkg.sv
sim/rename_core_tb.sv

// File: rename/free_list.sv
/*
  free list
  circular queue of free physical tags. the head tag is offered to
  dispatch and pops on a rename; a retire with a real destination
  pushes its old tag on the tail. pop and push can share an edge.
  after reset it holds the tags above the architectural range in order.
*/
module free_list #(
  parameter int num_phys = rename_pkg::default_num_phys
) (
  input  logic     clock,
  input  logic     reset,
  dispatch_if.free disp,
  retire_if.free   ret
);
  import rename_pkg::*;

  // tags not held by the map after reset
  localparam int depth = num_phys - num_arch_regs;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  typedef logic [ptr_w-1:0] fl_ptr_t;
  typedef logic [cnt_w-1:0] fl_cnt_t;

  phys_tag_t fl_mem [depth];
  fl_ptr_t   head;
  fl_ptr_t   tail;
  fl_cnt_t   count;
  logic      pop;
  logic      push;

  // depth is not a power of two in general, wrap by hand
  function automatic fl_ptr_t ptr_inc(input fl_ptr_t ptr);
    ptr_inc = (ptr == fl_ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop  = disp.renames;
  // p31 never enters the queue
  assign push = ret.valid && (ret.arch_reg != zero_reg);

  // head is visible to dispatch the cycle after it is written
  assign disp.t_new = fl_mem[head];
  assign disp.empty = (count == '0);

  ////////////////////
  // queue update
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        fl_mem[i] <= phys_tag_t'(num_arch_regs + i);
      end
      // full queue, tail wrapped onto head
      head  <= '0;
      tail  <= '0;
      count <= fl_cnt_t'(depth);
    end else begin
      if (pop) begin
        head <= ptr_inc(head);
      end
      if (push) begin
        fl_mem[tail] <= ret.t_old;
        tail         <= ptr_inc(tail);
      end
      // occupancy
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rename/map_table.sv
/*
  map table
  speculative architectural-to-physical map with a ready bit per entry.
  sources and the old destination mapping are read combinationally;
  a rename writes the new tag not ready, a completion broadcast sets
  the ready bit of every entry holding that tag. r31 stays at p31.
*/
module map_table #(
  parameter int num_phys = rename_pkg::default_num_phys
) (
  input  logic                  clock,
  input  logic                  reset,
  dispatch_if.map               disp,
  input  logic                  complete_valid,
  input  rename_pkg::phys_tag_t complete_tag
);
  import rename_pkg::*;

  phys_tag_t                map_tag [num_arch_regs];
  logic [num_arch_regs-1:0] map_ready;
  logic                     complete_hit;
  logic                     write_dest;

  // tags past the physical range can't be in the map
  assign complete_hit = complete_valid && (int'(complete_tag) < num_phys);

  // r31 entry is never overwritten
  assign write_dest = disp.renames && (disp.dest != zero_reg);

  ////////////////////
  // lookups
  ////////////////////

  // reads see the table before this instruction's own rename,
  // and only completions from earlier edges
  always_comb begin
    disp.t1       = map_tag[disp.src_a];
    disp.t1_ready = map_ready[disp.src_a];
    disp.t2       = map_tag[disp.src_b];
    disp.t2_ready = map_ready[disp.src_b];
    // old mapping, freed when this instruction retires
    disp.t_old    = map_tag[disp.dest];
  end

  ////////////////////
  // update
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, everything ready
      for (int i = 0; i < num_arch_regs; i++) begin
        map_tag[i] <= phys_tag_t'(i);
      end
      map_ready <= '1;
    end else begin
      // broadcast first
      if (complete_hit) begin
        for (int i = 0; i < num_arch_regs; i++) begin
          if (map_tag[i] == complete_tag) begin
            map_ready[i] <= 1'b1;
          end
        end
      end
      // rename last, so it wins on the same entry
      if (write_dest) begin
        map_tag[disp.dest]   <= disp.t_new;
        map_ready[disp.dest] <= 1'b0;
      end
    end
  end

endmodule

// File: rob/rob.sv
/*
  reorder buffer
  circular buffer of in-flight instructions, written at the tail on
  dispatch and retired in order from the head. a completion broadcast
  marks the entry whose new tag matches; r31 destinations enter already
  complete. the head view is combinational and pops when complete.
*/
module rob #(
  parameter int rob_depth = rename_pkg::default_rob_depth
) (
  input  logic                  clock,
  input  logic                  reset,
  dispatch_if.rob               disp,
  retire_if.rob                 ret,
  input  logic                  complete_valid,
  input  rename_pkg::phys_tag_t complete_tag,
  output logic                  full
);
  import rename_pkg::*;

  // power-of-two depth lets the pointers wrap on their own
  localparam int ptr_w = $clog2(rob_depth);

  typedef logic [ptr_w-1:0] rob_ptr_t;
  typedef logic [ptr_w:0]   rob_cnt_t;

  // entry payload
  arch_reg_t ent_dest  [rob_depth];
  phys_tag_t ent_t_new [rob_depth];
  phys_tag_t ent_t_old [rob_depth];

  // entry state
  logic [rob_depth-1:0] ent_valid;
  logic [rob_depth-1:0] ent_complete;
  logic [rob_depth-1:0] complete_match;

  rob_ptr_t head;
  rob_ptr_t tail;
  rob_cnt_t count;
  logic     pop;

  assign full = (count == rob_cnt_t'(rob_depth));

  ////////////////////
  // completion search
  ////////////////////

  // r31 entries carry no real tag and are skipped
  always_comb begin
    for (int i = 0; i < rob_depth; i++) begin
      complete_match[i] = complete_valid && ent_valid[i] &&
                          (ent_dest[i] != zero_reg) &&
                          (ent_t_new[i] == complete_tag);
    end
  end

  ////////////////////
  // head view
  ////////////////////

  assign pop          = ent_valid[head] && ent_complete[head];
  assign ret.valid    = pop;
  assign ret.arch_reg = ent_dest[head];
  assign ret.t_new    = ent_t_new[head];
  assign ret.t_old    = ent_t_old[head];

  ////////////////////
  // state update
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      ent_valid    <= '0;
      ent_complete <= '0;
      head         <= '0;
      tail         <= '0;
      count        <= '0;
    end else begin
      // broadcast first
      // the tail write below overrides its own bit
      ent_complete <= ent_complete | complete_match;
      if (pop) begin
        ent_valid[head] <= 1'b0;
        head            <= head + 1'b1;
      end
      if (disp.fire) begin
        ent_valid[tail]    <= 1'b1;
        // nothing to wait for on r31
        ent_complete[tail] <= (disp.dest == zero_reg);
        tail               <= tail + 1'b1;
      end
      // dispatch and retire can overlap
      case ({disp.fire, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // payload written at the tail on dispatch
  always_ff @(posedge clock) begin
    if (disp.fire) begin
      ent_dest[tail]  <= disp.dest;
      ent_t_new[tail] <= disp.t_new;
      ent_t_old[tail] <= disp.t_old;
    end
  end

endmodule

// File: sim/rename_core_tb.sv
/*
  rename core testbench
  random dispatch and completion traffic with long completion droughts,
  checked by assertions against the reference model in rename_tb_pkg
*/
module rename_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rename_pkg::*;
  import rename_tb_pkg::*;

  localparam int num_phys   = default_num_phys;
  localparam int rob_depth  = default_rob_depth;
  localparam int run_cycles = 2000;

  logic      clock;
  logic      reset;
  logic      dispatch_valid;
  arch_reg_t dispatch_dest;
  arch_reg_t dispatch_src_a;
  arch_reg_t dispatch_src_b;
  logic      complete_valid;
  phys_tag_t complete_tag;
  logic      dispatch_ready;
  phys_tag_t dispatch_t1;
  logic      dispatch_t1_ready;
  phys_tag_t dispatch_t2;
  logic      dispatch_t2_ready;
  phys_tag_t dispatch_t_new;
  phys_tag_t dispatch_t_old;
  logic      retire_valid;
  arch_reg_t retire_arch;
  phys_tag_t retire_t_new;
  phys_tag_t retire_t_old;

  // model view of the cycle in flight
  logic        exp_ready;
  logic [6:0]  exp_src_a;
  logic [6:0]  exp_src_b;
  phys_tag_t   exp_t_new;
  phys_tag_t   exp_t_old;
  logic        exp_renames;
  logic        exp_retire;
  // {arch, t_old} of the oldest entry
  logic [10:0] exp_head;
  phys_tag_t   exp_head_t_new;
  logic        exp_head_real;

  // rob full, free list empty, recycled tag, r31 retire, held stall
  logic [4:0] reached;
  int         quiet;

  rename_core #(
    .num_phys  (num_phys),
    .rob_depth (rob_depth)
  ) u_rename_core (.*);

  always #5 clock = ~clock;

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] want);
    $display("MISMATCH %s dut=%h model=%h", name, got, want);
    $display("*** TEST FAILED ***");
    $fatal(1, "check failed on %s", name);
  endtask

  // step the model one edge and drive the next request and completion
  task automatic advance_cycle();
    phys_tag_t pending [$];
    logic      valid;
    arch_reg_t dest;
    arch_reg_t src_a;
    arch_reg_t src_b;
    logic      cvalid;
    phys_tag_t ctag;
    @(posedge clock);
    if (reset) begin
      reset_model(num_phys);
    end else begin
      reached[0] |= (rob_dest_q.size() == rob_depth);
      reached[1] |= (free_tags.size() == 0);
      reached[2] |= exp_renames && (free_tags[0] < num_arch_regs);
      reached[3] |= exp_retire && (rob_dest_q[0] == zero_reg);
      reached[4] |= dispatch_valid && !exp_ready;
      step_model(dispatch_valid && exp_ready, dispatch_dest, complete_valid, complete_tag);
    end
    // stalled request held half the time
    valid = dispatch_valid;
    dest  = dispatch_dest;
    src_a = dispatch_src_a;
    src_b = dispatch_src_b;
    if (!(dispatch_valid && !exp_ready) || $urandom_range(1) == 0) begin
      valid = ($urandom_range(9) < 7);
      // about one in five targets r31
      dest  = ($urandom_range(4) == 0) ? zero_reg : arch_reg_t'($urandom_range(30));
      src_a = arch_reg_t'($urandom_range(31));
      src_b = arch_reg_t'($urandom_range(31));
    end
    cvalid = 1'b0;
    ctag   = '0;
    if (quiet > 0) begin
      quiet--;
    end else if ($urandom_range(49) == 0) begin
      // drought lets the ROB fill and the free list drain
      quiet = $urandom_range(100, 40);
    end else if ($urandom_range(9) < 6) begin
      foreach (rob_done_q[i]) begin
        if (!rob_done_q[i] && rob_dest_q[i] != zero_reg) begin
          pending.push_back(rob_t_new_q[i]);
        end
      end
      if (pending.size() > 0) begin
        cvalid = 1'b1;
        ctag   = pending[$urandom_range(pending.size() - 1)];
      end
    end else if ($urandom_range(9) == 0) begin
      // stray tag that is often not in flight
      cvalid = 1'b1;
      ctag   = phys_tag_t'($urandom_range(num_phys - 1));
    end
    dispatch_valid <= valid;
    dispatch_dest  <= dest;
    dispatch_src_a <= src_a;
    dispatch_src_b <= src_b;
    complete_valid <= cvalid;
    complete_tag   <= ctag;
    // expectations for the new request against the stepped model
    exp_ready   <= dispatch_allowed(dest, rob_depth);
    exp_src_a   <= {map_tags[src_a], map_ready_bits[src_a]};
    exp_src_b   <= {map_tags[src_b], map_ready_bits[src_b]};
    exp_t_new   <= (free_tags.size() > 0) ? free_tags[0] : '0;
    exp_t_old   <= map_tags[dest];
    exp_renames <= valid && dispatch_allowed(dest, rob_depth) && (dest != zero_reg);
    exp_retire  <= head_complete();
    if (rob_dest_q.size() > 0) begin
      exp_head       <= {rob_dest_q[0], rob_t_old_q[0]};
      exp_head_t_new <= rob_t_new_q[0];
      exp_head_real  <= (rob_dest_q[0] != zero_reg);
    end
  endtask

  ////////////////////
  // checks
  ////////////////////

  ready_chk: assert property (@(posedge clock) disable iff (reset)
      dispatch_ready == exp_ready)
    else report_mismatch("dispatch_ready", $sampled(dispatch_ready), $sampled(exp_ready));
  // sources see the map before this rename
  src_a_chk: assert property (@(posedge clock) disable iff (reset)
      dispatch_valid |-> {dispatch_t1, dispatch_t1_ready} == exp_src_a)
    else report_mismatch("dispatch_t1/dispatch_t1_ready",
                         $sampled({dispatch_t1, dispatch_t1_ready}), $sampled(exp_src_a));
  src_b_chk: assert property (@(posedge clock) disable iff (reset)
      dispatch_valid |-> {dispatch_t2, dispatch_t2_ready} == exp_src_b)
    else report_mismatch("dispatch_t2/dispatch_t2_ready",
                         $sampled({dispatch_t2, dispatch_t2_ready}), $sampled(exp_src_b));
  // free-list order
  t_new_chk: assert property (@(posedge clock) disable iff (reset)
      exp_renames |-> dispatch_t_new == exp_t_new)
    else report_mismatch("dispatch_t_new", $sampled(dispatch_t_new), $sampled(exp_t_new));
  t_old_chk: assert property (@(posedge clock) disable iff (reset)
      dispatch_valid |-> dispatch_t_old == exp_t_old)
    else report_mismatch("dispatch_t_old", $sampled(dispatch_t_old), $sampled(exp_t_old));
  // in-order retire
  retire_chk: assert property (@(posedge clock) disable iff (reset)
      retire_valid == exp_retire)
    else report_mismatch("retire_valid", $sampled(retire_valid), $sampled(exp_retire));
  head_chk: assert property (@(posedge clock) disable iff (reset)
      exp_retire |-> {retire_arch, retire_t_old} == exp_head)
    else report_mismatch("retire_arch/retire_t_old",
                         $sampled({retire_arch, retire_t_old}), $sampled(exp_head));
  head_t_new_chk: assert property (@(posedge clock) disable iff (reset)
      exp_retire && exp_head_real |-> retire_t_new == exp_head_t_new)
    else report_mismatch("retire_t_new", $sampled(retire_t_new), $sampled(exp_head_t_new));

  initial begin
    int waited;
    void'($urandom(32'h4a515077));
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_dest  = '0;
    dispatch_src_a = '0;
    dispatch_src_b = '0;
    complete_valid = 1'b0;
    complete_tag   = '0;
    exp_ready      = 1'b0;
    exp_renames    = 1'b0;
    exp_retire     = 1'b0;
    reached        = '0;
    quiet          = 0;
    waited         = 0;
    repeat (16) begin
      advance_cycle();
    end
    reset <= 1'b0;
    repeat (run_cycles) begin
      advance_cycle();
    end
    // keep going until every behavior has shown up
    while (!(&reached) && waited < run_cycles) begin
      advance_cycle();
      waited++;
    end
    // let the checks of the last edge finish
    @(negedge clock);
    if (&reached) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("not every behavior was reached before the timeout, reached=%b", reached);
      $display("*** TEST FAILED ***");
      $fatal(1, "behavior coverage incomplete");
    end
  end

endmodule

// File: sim/rename_tb_pkg.sv
/*
  rename reference model
  speculative map with ready bits, free-list order and ROB queue,
  stepped once per clock edge from the stimulus alone
*/
package rename_tb_pkg;
  import rename_pkg::*;

  // map and ready bits
  phys_tag_t map_tags [num_arch_regs];
  bit        map_ready_bits [num_arch_regs];
  // free tags, next allocation at index 0
  phys_tag_t free_tags [$];
  // rob, oldest first
  arch_reg_t rob_dest_q [$];
  phys_tag_t rob_t_new_q [$];
  phys_tag_t rob_t_old_q [$];
  bit        rob_done_q [$];

  // identity map, tags above the architectural range free in order
  function automatic void reset_model(input int num_phys);
    for (int i = 0; i < num_arch_regs; i++) begin
      map_tags[i]       = phys_tag_t'(i);
      map_ready_bits[i] = 1'b1;
    end
    free_tags.delete();
    for (int t = num_arch_regs; t < num_phys; t++) begin
      free_tags.push_back(phys_tag_t'(t));
    end
    rob_dest_q.delete();
    rob_t_new_q.delete();
    rob_t_old_q.delete();
    rob_done_q.delete();
  endfunction

  function automatic bit dispatch_allowed(input arch_reg_t dest, input int rob_depth);
    return (rob_dest_q.size() < rob_depth) && (free_tags.size() > 0 || dest == zero_reg);
  endfunction

  function automatic bit head_complete();
    return (rob_done_q.size() > 0) && rob_done_q[0];
  endfunction

  // one edge, every decision taken from the state before it
  function automatic void step_model(input bit fire, input arch_reg_t dest,
                                     input bit complete, input phys_tag_t tag);
    bit        retire;
    arch_reg_t head_dest;
    phys_tag_t head_t_old;
    phys_tag_t t_new;
    retire     = head_complete();
    head_dest  = zero_reg;
    head_t_old = '0;
    if (retire) begin
      head_dest  = rob_dest_q.pop_front();
      head_t_old = rob_t_old_q.pop_front();
      void'(rob_t_new_q.pop_front());
      void'(rob_done_q.pop_front());
    end
    // broadcast reaches the map and the in-flight entries
    if (complete) begin
      for (int i = 0; i < num_arch_regs; i++) begin
        if (map_tags[i] == tag) begin
          map_ready_bits[i] = 1'b1;
        end
      end
      foreach (rob_done_q[i]) begin
        if (rob_dest_q[i] != zero_reg && rob_t_new_q[i] == tag) begin
          rob_done_q[i] = 1'b1;
        end
      end
    end
    if (fire) begin
      t_new = (free_tags.size() > 0) ? free_tags[0] : '0;
      rob_dest_q.push_back(dest);
      rob_t_new_q.push_back(t_new);
      rob_t_old_q.push_back(map_tags[dest]);
      rob_done_q.push_back(dest == zero_reg);
      if (dest != zero_reg) begin
        void'(free_tags.pop_front());
        map_tags[dest]       = t_new;
        map_ready_bits[dest] = 1'b0;
      end
    end
    // old tag back on the tail, allocatable next cycle
    if (retire && head_dest != zero_reg) begin
      free_tags.push_back(head_t_old);
    end
  endfunction

endpackage

// File: source/rename_core.sv
/*
  rename core
  register rename and in-order retire: map table, free list and ROB
  behind a valid/ready dispatch port, a completion broadcast port in
  the role of the CDB, and a retire strobe for the ROB head.
  dispatch stalls on a full ROB, or on an empty free list unless the
  destination is the zero register.
*/
module rename_core #(
  parameter int num_phys  = rename_pkg::default_num_phys,
  parameter int rob_depth = rename_pkg::default_rob_depth
) (
  input  logic                  clock,
  input  logic                  reset,

  // dispatch request
  input  logic                  dispatch_valid,
  input  rename_pkg::arch_reg_t dispatch_dest,
  input  rename_pkg::arch_reg_t dispatch_src_a,
  input  rename_pkg::arch_reg_t dispatch_src_b,

  // completion broadcast, no back-pressure
  input  logic                  complete_valid,
  input  rename_pkg::phys_tag_t complete_tag,

  // dispatch response, same cycle
  output logic                  dispatch_ready,
  output rename_pkg::phys_tag_t dispatch_t1,
  output logic                  dispatch_t1_ready,
  output rename_pkg::phys_tag_t dispatch_t2,
  output logic                  dispatch_t2_ready,
  output rename_pkg::phys_tag_t dispatch_t_new,
  output rename_pkg::phys_tag_t dispatch_t_old,

  // retiring head
  output logic                  retire_valid,
  output rename_pkg::arch_reg_t retire_arch,
  output rename_pkg::phys_tag_t retire_t_new,
  output rename_pkg::phys_tag_t retire_t_old
);
  import rename_pkg::*;

  dispatch_if disp ();
  retire_if   ret ();

  logic rob_full;
  logic dest_is_zero;

  ////////////////////
  // dispatch handshake
  ////////////////////

  // r31 needs no free tag
  assign dest_is_zero   = (dispatch_dest == zero_reg);
  assign dispatch_ready = !rob_full && (!disp.empty || dest_is_zero);

  assign disp.fire    = dispatch_valid && dispatch_ready;
  // only a real destination pulls a tag and updates the map
  assign disp.renames = disp.fire && !dest_is_zero;
  assign disp.dest    = dispatch_dest;
  assign disp.src_a   = dispatch_src_a;
  assign disp.src_b   = dispatch_src_b;

  // rename results out
  assign dispatch_t1       = disp.t1;
  assign dispatch_t1_ready = disp.t1_ready;
  assign dispatch_t2       = disp.t2;
  assign dispatch_t2_ready = disp.t2_ready;
  assign dispatch_t_new    = disp.t_new;
  assign dispatch_t_old    = disp.t_old;

  // retire view of the ROB head
  assign retire_valid = ret.valid;
  assign retire_arch  = ret.arch_reg;
  assign retire_t_new = ret.t_new;
  assign retire_t_old = ret.t_old;

  ////////////////////
  // blocks
  ////////////////////

  map_table #(
    .num_phys (num_phys)
  ) u_map_table (
    .clock          (clock),
    .reset          (reset),
    .disp           (disp),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag)
  );

  free_list #(
    .num_phys (num_phys)
  ) u_free_list (
    .clock (clock),
    .reset (reset),
    .disp  (disp),
    .ret   (ret)
  );

  rob #(
    .rob_depth (rob_depth)
  ) u_rob (
    .clock          (clock),
    .reset          (reset),
    .disp           (disp),
    .ret            (ret),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .full           (rob_full)
  );

endmodule
